/* hdl/mp_params.svh */
// Fixed encodings of the MP instruction subset; codes left out here decode as illegal
// Queue depth must be at least 2

`ifndef MP_PARAMS_SVH
`define MP_PARAMS_SVH

// Datapath width
`define MP_XLEN 32

// Entries between issue and MALU
`define MP_QUEUE_DEPTH 4

// Subclass codes carried on issue_sclass
`define MP_SCLASS_EQU  4'b0000
`define MP_SCLASS_LTU  4'b0001
`define MP_SCLASS_GTU  4'b0010
`define MP_SCLASS_ADD3 4'b0100
`define MP_SCLASS_ADD2 4'b0101
`define MP_SCLASS_SUB3 4'b0110
`define MP_SCLASS_SUB2 4'b0111
`define MP_SCLASS_SLLI 4'b1000
`define MP_SCLASS_SLL  4'b1001
`define MP_SCLASS_SRLI 4'b1010
`define MP_SCLASS_SRL  4'b1011

// 4'b0011 and 4'b1100..4'b1111 are reserved (ACC1, ACC2, MAC and spare)

`endif

/* hdl/mp_pkg.sv */
// Types shared by issue, queue and MALU
// Word width comes from MP_XLEN; a double word is always two words

`include "mp_params.svh"

package mp_pkg;

    // One register word
    typedef logic [`MP_XLEN-1:0] word_t;

    // Full MP result, written back as two beats
    typedef logic [2*`MP_XLEN-1:0] dword_t;

    // Coprocessor register index
    typedef logic [3:0] reg_idx_t;

    // Raw subclass field of the instruction
    typedef logic [3:0] sclass_t;

    // Internal operation after folding
    typedef enum logic [2:0] {
        OP_EQU, // Equal, chained by rs3[0]
        OP_LTU, // Unsigned below
        OP_GTU, // Unsigned above
        OP_ADD, // a + b + c
        OP_SUB, // a - b - c
        OP_SLL, // {b,a} << c[5:0]
        OP_SRL  // {b,a} >> c[5:0]
    } mp_op_t;

endpackage

/* hdl/mp_issue.sv */
// One instruction in flight; a new issue_req is taken only once the stage is idle again
// Illegal subclasses are acknowledged and dropped with a one cycle issue_illegal pulse

`include "mp_params.svh"

module mp_issue
    import mp_pkg::*;
(
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     issue_req,     // Request from the core
    input  word_t    issue_rs1,
    input  word_t    issue_rs2,
    input  word_t    issue_rs3,
    input  word_t    issue_imm,
    input  sclass_t  issue_sclass,
    input  reg_idx_t issue_rd,
    output logic     issue_ack,
    output logic     issue_illegal, // Pulse for an unknown subclass
    output logic     in_req,        // Towards the queue
    output mp_op_t   in_op,
    output word_t    in_a,
    output word_t    in_b,
    output word_t    in_c,
    output reg_idx_t in_rd,
    input  logic     in_ack
);

    typedef enum logic [1:0] {
        IDLE,
        SEND,         // in_req high, waiting for queue ack
        WAIT_ACK_LOW, // Queue closing its half of the handshake
        RELEASE       // Waiting for the core to drop req
    } issue_state_t;

    issue_state_t state;

    mp_op_t dec_op;    // Folded operation
    word_t  dec_c;     // Third operand or shift amount
    logic   dec_legal;

    // Fold immediate and two-operand forms onto the register forms
    always_comb begin
        dec_op    = OP_ADD;
        dec_c     = issue_rs3;
        dec_legal = 1'b1;
        case (issue_sclass)
            `MP_SCLASS_EQU:  dec_op = OP_EQU;
            `MP_SCLASS_LTU:  dec_op = OP_LTU;
            `MP_SCLASS_GTU:  dec_op = OP_GTU;
            `MP_SCLASS_ADD3: dec_op = OP_ADD;
            `MP_SCLASS_ADD2: begin
                dec_op = OP_ADD;
                dec_c  = '0; // No third addend
            end
            `MP_SCLASS_SUB3: dec_op = OP_SUB;
            `MP_SCLASS_SUB2: begin
                dec_op = OP_SUB;
                dec_c  = '0;
            end
            `MP_SCLASS_SLL:  dec_op = OP_SLL;
            `MP_SCLASS_SLLI: begin
                dec_op = OP_SLL;
                dec_c  = issue_imm; // Amount from the immediate
            end
            `MP_SCLASS_SRL:  dec_op = OP_SRL;
            `MP_SCLASS_SRLI: begin
                dec_op = OP_SRL;
                dec_c  = issue_imm;
            end
            default:         dec_legal = 1'b0;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state         <= IDLE;
            issue_ack     <= 1'b0;
            issue_illegal <= 1'b0;
            in_req        <= 1'b0;
        end else begin
            issue_illegal <= 1'b0;
            if (issue_ack && !issue_req) begin
                issue_ack <= 1'b0; // Core closed its handshake
            end
            case (state)
                IDLE: begin
                    if (issue_req) begin
                        issue_ack <= 1'b1;
                        if (dec_legal) begin
                            in_req <= 1'b1;
                            state  <= SEND;
                        end else begin
                            issue_illegal <= 1'b1; // Nothing sent on
                            state         <= RELEASE;
                        end
                    end
                end
                SEND: begin
                    if (in_ack) begin
                        in_req <= 1'b0;
                        state  <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: if (!in_ack) state <= RELEASE;
                RELEASE:      if (!issue_ack) state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

    // Decoded payload, held until the queue acks
    always_ff @(posedge g_clk) begin
        if (state == IDLE && issue_req && dec_legal) begin
            in_op <= dec_op;
            in_a  <= issue_rs1;
            in_b  <= issue_rs2;
            in_c  <= dec_c;
            in_rd <= issue_rd;
        end
    end

    // Queue must have closed the last transfer before a new one opens
    a_req_after_ack_low: assert property (
        @(posedge g_clk) disable iff (!g_resetn) $rose(in_req) |-> !in_ack);

endmodule

/* hdl/mp_queue.sv */
// Circular buffer between issue and MALU with a four-phase handshake on both sides
// Depth from MP_QUEUE_DEPTH; entries leave in the order they came in

`include "mp_params.svh"

module mp_queue
    import mp_pkg::*;
(
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     in_req,  // Producer side
    input  mp_op_t   in_op,
    input  word_t    in_a,
    input  word_t    in_b,
    input  word_t    in_c,
    input  reg_idx_t in_rd,
    output logic     in_ack,
    output logic     out_req, // Consumer side
    output mp_op_t   out_op,
    output word_t    out_a,
    output word_t    out_b,
    output word_t    out_c,
    output reg_idx_t out_rd,
    input  logic     out_ack
);

    localparam int DEPTH = `MP_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    mp_op_t   op_mem [DEPTH];
    word_t    a_mem  [DEPTH];
    word_t    b_mem  [DEPTH];
    word_t    c_mem  [DEPTH];
    reg_idx_t rd_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic push; // One per input handshake
    logic pop;  // One per output handshake

    assign full = (count == CNT_W'(DEPTH));
    assign push = in_req && !in_ack && !full;
    assign pop  = out_req && out_ack;

    // Input phase tracker
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            in_ack <= 1'b0;
        end else if (push) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0; // Producer dropped req
        end
    end

    // Output phase tracker raising a new req only after ack is seen low
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            out_req <= 1'b0;
        end else if (pop) begin
            out_req <= 1'b0;
        end else if (!out_req && !out_ack && count != '0) begin
            out_req <= 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge g_clk) begin
        if (push) begin
            op_mem[wr_ptr] <= in_op;
            a_mem[wr_ptr]  <= in_a;
            b_mem[wr_ptr]  <= in_b;
            c_mem[wr_ptr]  <= in_c;
            rd_mem[wr_ptr] <= in_rd;
        end
    end

    // Head entry stays stable while out_req is up
    assign out_op = op_mem[rd_ptr];
    assign out_a  = a_mem[rd_ptr];
    assign out_b  = b_mem[rd_ptr];
    assign out_c  = c_mem[rd_ptr];
    assign out_rd = rd_mem[rd_ptr];

    // A push only lands on a free slot
    a_no_overflow: assert property (
        @(posedge g_clk) disable iff (!g_resetn) push |-> (wr_ptr != rd_ptr || count == '0));

    // A pop only takes a filled slot
    a_no_pop_empty: assert property (
        @(posedge g_clk) disable iff (!g_resetn) pop |-> (wr_ptr != rd_ptr || full));

endmodule

/* hdl/mp_malu.sv */
// Two writeback beats per instruction, high word first; register file always accepts
// Result is taken when out_req is accepted, operands need not hold after that

module mp_malu
    import mp_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       out_req,  // From the queue
    input  mp_op_t     out_op,
    input  word_t      out_a,
    input  word_t      out_b,
    input  word_t      out_c,
    input  reg_idx_t   out_rd,
    output logic       out_ack,
    output logic [3:0] wb_ben,   // All ones on a beat
    output logic       wb_hi,    // Beat carries the upper word
    output reg_idx_t   wb_rd,
    output word_t      wb_wdata
);

    typedef enum logic [1:0] {
        IDLE,
        BEAT_HI,
        BEAT_LO,
        WAIT_REQ_LOW
    } malu_state_t;

    // One bit wider than a double word, top bit is the borrow
    typedef logic [$bits(dword_t):0] sum_t;

    malu_state_t state;

    word_t  pre_c;      // Third operand, zero for compares
    dword_t pre_sum;    // b + c
    logic   sub;
    sum_t   add_lhs;
    sum_t   add_rhs;
    sum_t   add_res;
    logic   is_lt;      // a below b
    logic   is_eq;
    dword_t shf_in;
    dword_t shf_out;
    dword_t alu_result;
    dword_t result_q;   // Latched at accept

    function automatic dword_t bit_rev(input dword_t x);
        dword_t r;
        for (int i = 0; i < $bits(dword_t); i++) begin
            r[i] = x[$bits(dword_t)-1-i];
        end
        return r;
    endfunction

    // Shared adder, subtract for OP_SUB and all compares
    assign pre_c   = (out_op == OP_ADD || out_op == OP_SUB) ? out_c : '0;
    assign pre_sum = dword_t'(out_b) + dword_t'(pre_c);
    assign sub     = (out_op != OP_ADD);
    assign add_lhs = sum_t'(out_a);
    assign add_rhs = sub ? ~sum_t'(pre_sum) : sum_t'(pre_sum);
    assign add_res = add_lhs + add_rhs + sum_t'(sub);

    assign is_lt = add_res[$bits(dword_t)];      // Negative difference
    assign is_eq = (add_res[$bits(dword_t)-1:0] == '0);

    // Single right funnel shifter, left shift done by bit reversal
    assign shf_in  = (out_op == OP_SLL) ? bit_rev({out_b, out_a}) : {out_b, out_a};
    assign shf_out = shf_in >> out_c[5:0];

    always_comb begin
        case (out_op)
            OP_EQU:  alu_result = dword_t'(is_eq && out_c[0]);
            OP_LTU:  alu_result = dword_t'(is_lt || (is_eq && out_c[0]));
            OP_GTU:  alu_result = dword_t'((!is_lt && !is_eq) || (is_eq && out_c[0]));
            OP_SLL:  alu_result = bit_rev(shf_out);
            OP_SRL:  alu_result = shf_out;
            default: alu_result = add_res[$bits(dword_t)-1:0]; // ADD and SUB
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state   <= IDLE;
            out_ack <= 1'b0;
            wb_ben  <= 4'b0000;
            wb_hi   <= 1'b0;
        end else begin
            wb_ben <= 4'b0000; // Beats last one cycle
            wb_hi  <= 1'b0;
            case (state)
                IDLE: begin
                    if (out_req) begin
                        out_ack <= 1'b1;
                        state   <= BEAT_HI;
                    end
                end
                BEAT_HI: begin
                    wb_ben <= 4'b1111;
                    wb_hi  <= 1'b1;
                    state  <= BEAT_LO;
                end
                BEAT_LO: begin
                    wb_ben <= 4'b1111;
                    state  <= WAIT_REQ_LOW;
                end
                WAIT_REQ_LOW: begin
                    if (!out_req) begin
                        out_ack <= 1'b0; // Close queue handshake
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload, no reset needed
    always_ff @(posedge g_clk) begin
        if (state == IDLE && out_req) begin
            result_q <= alu_result;
            wb_rd    <= out_rd;
        end
        if (state == BEAT_HI) wb_wdata <= result_q[$bits(dword_t)-1:$bits(word_t)];
        if (state == BEAT_LO) wb_wdata <= result_q[$bits(word_t)-1:0];
    end

    // Upper beat is always followed directly by the lower one
    a_beat_pair: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (wb_ben == 4'b1111 && wb_hi) |=> (wb_ben == 4'b1111 && !wb_hi));

endmodule

/* hdl/mp_cop_top.sv */
// MP arithmetic slice: issue decode, instruction queue, MALU with two-beat writeback
// Writeback has no back-pressure; results leave in issue order

module mp_cop_top
    import mp_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       issue_req,
    input  word_t      issue_rs1,
    input  word_t      issue_rs2,
    input  word_t      issue_rs3,
    input  word_t      issue_imm,
    input  sclass_t    issue_sclass,
    input  reg_idx_t   issue_rd,
    output logic       issue_ack,
    output logic       issue_illegal,
    output logic [3:0] wb_ben,
    output logic       wb_hi,
    output reg_idx_t   wb_rd,
    output word_t      wb_wdata
);

    // Issue to queue
    logic     in_req;
    logic     in_ack;
    mp_op_t   in_op;
    word_t    in_a;
    word_t    in_b;
    word_t    in_c;
    reg_idx_t in_rd;

    // Queue to MALU
    logic     out_req;
    logic     out_ack;
    mp_op_t   out_op;
    word_t    out_a;
    word_t    out_b;
    word_t    out_c;
    reg_idx_t out_rd;

    mp_issue u_issue (
        .g_clk, .g_resetn,
        .issue_req, .issue_rs1, .issue_rs2, .issue_rs3, .issue_imm,
        .issue_sclass, .issue_rd, .issue_ack, .issue_illegal,
        .in_req, .in_op, .in_a, .in_b, .in_c, .in_rd, .in_ack
    );

    mp_queue u_queue (
        .g_clk, .g_resetn,
        .in_req, .in_op, .in_a, .in_b, .in_c, .in_rd, .in_ack,
        .out_req, .out_op, .out_a, .out_b, .out_c, .out_rd, .out_ack
    );

    mp_malu u_malu (
        .g_clk, .g_resetn,
        .out_req, .out_op, .out_a, .out_b, .out_c, .out_rd, .out_ack,
        .wb_ben, .wb_hi, .wb_rd, .wb_wdata
    );

endmodule

/* bench/mp_tb.sv */
// Drives mp_cop_top through the four-phase issue port and checks every writeback beat
// Stops at the first mismatch; the run is bounded by a cycle counter

`include "mp_params.svh"

module mp_tb
    import mp_pkg::*;
();

    localparam int N_INSTR        = 300;               // Issues per run
    localparam int TIMEOUT_CYCLES = N_INSTR * 16 + 100;
    localparam int DRAIN_CYCLES   = 100;               // Bound on the final drain

    logic       g_clk = 1'b0;
    logic       g_resetn;
    logic       issue_req;
    word_t      issue_rs1;
    word_t      issue_rs2;
    word_t      issue_rs3;
    word_t      issue_imm;
    sclass_t    issue_sclass;
    reg_idx_t   issue_rd;
    logic       issue_ack;
    logic       issue_illegal;
    logic [3:0] wb_ben;
    logic       wb_hi;
    reg_idx_t   wb_rd;
    word_t      wb_wdata;

    // One entry per expected beat with the high beat queued first
    reg_idx_t exp_rd [$];
    word_t    exp_word [$];
    logic     exp_hi [$];

    reg_idx_t e_rd;   // Entry under check
    word_t    e_word;
    logic     e_hi;

    logic [31:0] lfsr_state = 32'h79;
    int          cycle_cnt  = 0;
    int          issued     = 0;

    mp_cop_top DUT (
        .g_clk, .g_resetn,
        .issue_req, .issue_rs1, .issue_rs2, .issue_rs3, .issue_imm,
        .issue_sclass, .issue_rd, .issue_ack, .issue_illegal,
        .wb_ben, .wb_hi, .wb_rd, .wb_wdata
    );

    always #20 g_clk = ~g_clk; // Period 40

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Half the operands are carry/borrow edges
    task automatic pick_operand(output word_t w);
        logic [31:0] sel;
        take_bits(2, sel);
        case (sel[1:0])
            2'd0:    w = '0;
            2'd1:    w = '1;
            default: take_bits(32, w);
        endcase
    endtask

    function automatic logic sclass_legal(input sclass_t sc);
        case (sc)
            `MP_SCLASS_EQU, `MP_SCLASS_LTU, `MP_SCLASS_GTU,
            `MP_SCLASS_ADD2, `MP_SCLASS_ADD3, `MP_SCLASS_SUB2, `MP_SCLASS_SUB3,
            `MP_SCLASS_SLL, `MP_SCLASS_SLLI, `MP_SCLASS_SRL, `MP_SCLASS_SRLI: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Expected 64-bit result straight from the instruction rules
    function automatic dword_t mp_ref(input sclass_t sc, input word_t rs1, input word_t rs2,
                                      input word_t rs3, input word_t imm);
        dword_t a;
        dword_t b;
        dword_t c;
        dword_t pair;
        a    = {32'd0, rs1};
        b    = {32'd0, rs2};
        c    = {32'd0, rs3};
        pair = {rs2, rs1}; // rs2 is the upper word
        case (sc)
            `MP_SCLASS_ADD2: return a + b;
            `MP_SCLASS_ADD3: return a + b + c;
            `MP_SCLASS_SUB2: return a - b;       // Wraps to 64-bit two's complement
            `MP_SCLASS_SUB3: return a - b - c;
            `MP_SCLASS_SLL:  return pair << rs3[5:0];
            `MP_SCLASS_SLLI: return pair << imm[5:0];
            `MP_SCLASS_SRL:  return pair >> rs3[5:0];
            `MP_SCLASS_SRLI: return pair >> imm[5:0];
            `MP_SCLASS_EQU:  return {63'd0, (rs1 == rs2) && rs3[0]};
            `MP_SCLASS_LTU:  return {63'd0, (rs1 < rs2) || ((rs1 == rs2) && rs3[0])};
            `MP_SCLASS_GTU:  return {63'd0, (rs1 > rs2) || ((rs1 == rs2) && rs3[0])};
            default:         return '0;
        endcase
    endfunction

    // Full four-phase issue with expected beats queued for legal codes
    task automatic issue_one(input sclass_t sc, input word_t rs1, input word_t rs2,
                             input word_t rs3, input word_t imm, input reg_idx_t rd);
        logic   legal;
        dword_t res;
        legal = sclass_legal(sc);
        res   = mp_ref(sc, rs1, rs2, rs3, imm);
        @(posedge g_clk);
        if (legal) begin
            exp_rd.push_back(rd);
            exp_word.push_back(res[63:32]);
            exp_hi.push_back(1'b1);
            exp_rd.push_back(rd);
            exp_word.push_back(res[31:0]);
            exp_hi.push_back(1'b0);
        end
        issue_req    <= 1'b1;
        issue_rs1    <= rs1;
        issue_rs2    <= rs2;
        issue_rs3    <= rs3;
        issue_imm    <= imm;
        issue_sclass <= sc;
        issue_rd     <= rd;
        @(negedge g_clk);
        while (!issue_ack) @(negedge g_clk);
        // Illegal pulse lines up with the ack edge
        assert (issue_illegal == !legal) else
            abort_run($sformatf("ERROR t=%0t issue_illegal: got %b expected %b",
                                $time, issue_illegal, !legal));
        @(posedge g_clk);
        issue_req <= 1'b0;
        @(negedge g_clk);
        while (issue_ack) @(negedge g_clk);
        issued++;
    endtask

    task automatic arith_edges();
        sclass_t codes [4];
        codes = '{`MP_SCLASS_ADD2, `MP_SCLASS_ADD3, `MP_SCLASS_SUB2, `MP_SCLASS_SUB3};
        foreach (codes[i]) begin
            issue_one(codes[i], '1, '1, '1, 32'h0, 4'(i));        // Max carry
            issue_one(codes[i], '0, '0, '0, 32'h0, 4'(i + 4));
            issue_one(codes[i], '0, '1, '1, 32'h0, 4'(i + 8));    // Deep borrow
            issue_one(codes[i], '1, 32'h1, 32'h0, 32'h0, 4'(i + 12));
        end
    endtask

    task automatic compare_edges();
        sclass_t codes [3];
        word_t   lhs [3];
        word_t   rhs [3];
        codes = '{`MP_SCLASS_EQU, `MP_SCLASS_LTU, `MP_SCLASS_GTU};
        lhs   = '{32'h8000_0001, 32'h0000_0005, 32'hFFFF_FFFF}; // Equal, below, above
        rhs   = '{32'h8000_0001, 32'hFFFF_FFF0, 32'h0000_0000};
        foreach (codes[i]) begin
            for (int j = 0; j < 3; j++) begin
                for (int k = 0; k < 2; k++) begin
                    // Only rs3 bit 0 may matter
                    issue_one(codes[i], lhs[j], rhs[j], 32'hFFFF_FFFE | word_t'(k),
                              32'h0, 4'(j * 2 + k));
                end
            end
        end
    endtask

    task automatic shift_edges();
        logic [5:0] amts [5];
        word_t      amt_word;
        amts = '{6'd0, 6'd31, 6'd32, 6'd63, 6'd45};
        foreach (amts[i]) begin
            amt_word = 32'hDEAD_BEC0 | word_t'(amts[i]); // Junk above bit 5
            issue_one(`MP_SCLASS_SLL,  32'h89AB_CDEF, 32'h0123_4567, amt_word, ~amt_word,
                      4'(i));
            issue_one(`MP_SCLASS_SLLI, 32'h89AB_CDEF, 32'h0123_4567, ~amt_word, amt_word,
                      4'(i + 5));
            issue_one(`MP_SCLASS_SRL,  32'hF0F0_0F0F, 32'h8765_4321, amt_word, ~amt_word,
                      4'(i + 10));
            issue_one(`MP_SCLASS_SRLI, 32'hF0F0_0F0F, 32'h8765_4321, ~amt_word, amt_word,
                      4'(i + 11));
        end
    endtask

    task automatic reserved_codes();
        sclass_t bad [5];
        bad = '{4'b0011, 4'b1100, 4'b1101, 4'b1110, 4'b1111}; // Reserved codes
        foreach (bad[i]) begin
            issue_one(bad[i], 32'h1111_1111, 32'h2222_2222, 32'h3, 32'h4, 4'hF);
        end
    endtask

    // Back-to-back issues with random codes including illegal ones
    task automatic burst_issues(input int count);
        logic [31:0] bits;
        sclass_t     sc;
        word_t       rs1;
        word_t       rs2;
        word_t       rs3;
        word_t       imm;
        reg_idx_t    rd;
        repeat (count) begin
            take_bits(4, bits);
            sc = sclass_t'(bits);
            pick_operand(rs1);
            pick_operand(rs2);
            pick_operand(rs3);
            take_bits(32, imm);
            take_bits(4, bits);
            rd = reg_idx_t'(bits);
            issue_one(sc, rs1, rs2, rs3, imm, rd);
        end
    endtask

    // Beats sampled mid-cycle against the expected queue
    always @(negedge g_clk) begin
        if (g_resetn && wb_ben != 4'b0000) begin
            assert (wb_ben == 4'b1111) else
                abort_run($sformatf("ERROR t=%0t wb_ben: got %b expected %b",
                                    $time, wb_ben, 4'b1111));
            assert (exp_word.size() != 0) else
                abort_run("Writeback beat appeared with no result outstanding");
            e_rd   = exp_rd.pop_front();
            e_word = exp_word.pop_front();
            e_hi   = exp_hi.pop_front();
            assert (wb_hi == e_hi) else
                abort_run($sformatf("ERROR t=%0t wb_hi: got %b expected %b",
                                    $time, wb_hi, e_hi));
            assert (wb_rd == e_rd) else
                abort_run($sformatf("ERROR t=%0t wb_rd: got %h expected %h",
                                    $time, wb_rd, e_rd));
            assert (wb_wdata == e_word) else
                abort_run($sformatf("ERROR t=%0t wb_wdata: got %h expected %h",
                                    $time, wb_wdata, e_word));
        end
    end

    // Watchdog
    always @(posedge g_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: run did not finish within the cycle limit");
        end
    end

    initial begin
        g_resetn     <= 1'b0;
        issue_req    <= 1'b0;
        issue_rs1    <= '0;
        issue_rs2    <= '0;
        issue_rs3    <= '0;
        issue_imm    <= '0;
        issue_sclass <= '0;
        issue_rd     <= '0;
        repeat (8) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        assert (issue_ack == 1'b0) else
            abort_run($sformatf("ERROR t=%0t issue_ack: got %b expected %b",
                                $time, issue_ack, 1'b0));
        assert (issue_illegal == 1'b0) else
            abort_run($sformatf("ERROR t=%0t issue_illegal: got %b expected %b",
                                $time, issue_illegal, 1'b0));
        assert (wb_ben == 4'b0000) else
            abort_run($sformatf("ERROR t=%0t wb_ben: got %b expected %b",
                                $time, wb_ben, 4'b0000));
        repeat (5) @(negedge g_clk); // Quiet time where any beat is flagged

        arith_edges();
        compare_edges();
        shift_edges();
        reserved_codes();
        burst_issues(N_INSTR - issued);

        // Bounded drain and then a watch for stray beats
        for (int n = 0; n < DRAIN_CYCLES && exp_word.size() != 0; n++) begin
            @(negedge g_clk);
        end
        repeat (20) @(negedge g_clk);
        assert (exp_word.size() == 0) else
            abort_run("Expected results left over at end of run");
        $display("Done: no errors");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/mp_pkg.sv
hdl/mp_issue.sv
hdl/mp_queue.sv
hdl/mp_malu.sv
hdl/mp_cop_top.sv
bench/mp_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mp_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
